// ==== rtl/bus_map_pkg.sv ====
package bus_map_pkg;

  typedef logic [1:0] map_mode_t;
  typedef logic [10:0] chipselect_t;

  localparam map_mode_t map_boot = 2'd3; // Any other code selects the default map

  localparam int cs_ssram = 0;
  localparam int cs_encoder = 1;
  localparam int cs_switches = 2;
  localparam int cs_uart1 = 3;
  localparam int cs_uart0 = 4;
  localparam int cs_led_matrix = 5;
  localparam int cs_int_ram = 6;
  localparam int cs_int_rom = 7;
  localparam int cs_lcd = 8;
  localparam int cs_vectors = 9;
  localparam int cs_sd_card = 10;

  localparam logic [31:0] boot_ram_base = 32'h0000_0000, boot_ram_limit = 32'h0000_3fff;
  localparam logic [31:0] boot_ssram_base = 32'h0000_4000, boot_ssram_limit = 32'h000f_ffff;
  localparam logic [31:0] ssram_base = 32'h0000_0000, ssram_limit = 32'h000f_ffff;
  localparam logic [31:0] led_base = 32'h0080_0000, led_limit = 32'h0080_07ff;
  localparam logic [31:0] uart0_base = 32'h0080_0800, uart0_limit = 32'h0080_0807;
  localparam logic [31:0] uart1_base = 32'h0080_0808, uart1_limit = 32'h0080_080f;
  localparam logic [31:0] switches_base = 32'h0080_0810, switches_limit = 32'h0080_0813;
  localparam logic [31:0] encoder_base = 32'h0080_0814, encoder_limit = 32'h0080_081f;
  localparam logic [31:0] sd_card_base = 32'h0080_0820, sd_card_limit = 32'h0080_0827;
  localparam logic [31:0] lcd_base = 32'h0080_0c00, lcd_limit = 32'h0080_0cff;
  localparam logic [31:0] int_ram_base = 32'hffff_8000, int_ram_limit = 32'hffff_bfff;
  localparam logic [31:0] int_rom_base = 32'hffff_c000, int_rom_limit = 32'hffff_ffbf;
  localparam logic [31:0] vectors_base = 32'hffff_ffc0, vectors_limit = 32'hffff_ffff;

endpackage

// ==== rtl/bus_xfer_pkg.sv ====
package bus_xfer_pkg;

  localparam int master_cpu = 0;
  localparam int master_vga = 1;

  typedef logic [1:0] grant_t; // At most one bit set

  typedef enum logic [1:0] {
    seq_idle,
    seq_start,
    seq_pre,
    seq_post
  } seq_state_t;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] be_t;

  // Grant codes used by the arbiter
  localparam grant_t grant_none = 2'b00;
  localparam grant_t grant_cpu = 2'b01;
  localparam grant_t grant_vga = 2'b10;

endpackage

// ==== rtl/bus_request_if.sv ====
`timescale 1ns/10ps

interface bus_request_if import bus_xfer_pkg::*; ();

  addr_t address;
  logic read;
  logic write;
  be_t be;
  data_t writedata;

  modport mux (
    output address,
    output read,
    output write,
    output be,
    output writedata
  );

  modport sequencer (
    input read,
    input write
  );

  modport decoder (
    input address
  );

endinterface

// ==== rtl/bus_sequencer.sv ====
`timescale 1ns/10ps

module bus_sequencer import bus_xfer_pkg::*; #(
  parameter logic [3:0] WAIT_STATES = 4'd0
) (
  input logic clock,
  input logic reset_n,
  input logic cpu_read,
  input logic cpu_write,
  input logic vga_read,
  bus_request_if.sequencer bus,
  output grant_t grant,
  output logic cycle_active,
  output logic start,
  output logic cpu_wait,
  output logic vga_wait
);

  seq_state_t state;
  seq_state_t state_next;
  grant_t grant_next;
  logic [3:0] delay;
  logic [3:0] delay_next;
  logic request_held;

  assign request_held = bus.read | bus.write; // Granted master still asking
  assign cycle_active = (state != seq_idle);
  assign start = (state == seq_start);

  // Only the granted master is released, and only in post
  assign cpu_wait = !(grant[master_cpu] && state == seq_post);
  assign vga_wait = !(grant[master_vga] && state == seq_post);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= seq_idle;
      grant <= grant_none;
      delay <= 4'd0;
    end else begin
      state <= state_next;
      grant <= grant_next;
      delay <= delay_next;
    end
  end

  always_comb begin
    state_next = state;
    grant_next = grant;
    delay_next = delay;
    case (state)
      seq_idle: begin
        if (cpu_read | cpu_write) begin // CPU wins ties
          state_next = seq_start;
          grant_next = grant_cpu;
        end else if (vga_read) begin
          state_next = seq_start;
          grant_next = grant_vga;
        end
      end
      seq_start: begin
        delay_next = WAIT_STATES;
        if (request_held) begin
          state_next = seq_pre;
        end else begin
          state_next = seq_idle;
          grant_next = grant_none;
        end
      end
      seq_pre: begin
        if (!request_held) begin // Abort
          state_next = seq_idle;
          grant_next = grant_none;
          delay_next = 4'd0;
        end else if (delay == 4'd0) begin
          state_next = seq_post;
        end else begin
          delay_next = delay - 4'd1;
        end
      end
      seq_post: begin
        if (!request_held) begin
          state_next = seq_idle;
          grant_next = grant_none;
        end
      end
      default: begin
        state_next = seq_idle;
        grant_next = grant_none;
      end
    endcase
  end

endmodule

// ==== rtl/master_mux.sv ====
`timescale 1ns/10ps

module master_mux import bus_xfer_pkg::*; (
  input addr_t cpu_address,
  input logic cpu_read,
  input logic cpu_write,
  input be_t cpu_be,
  input data_t cpu_writedata,
  input addr_t vga_address,
  input logic vga_read,
  input grant_t grant,
  bus_request_if.mux bus
);

  logic sel_cpu;
  logic sel_vga;

  assign sel_cpu = grant[master_cpu];
  assign sel_vga = grant[master_vga];

  // Masked contributions ORed together, so no grant gives all zero
  assign bus.address = ({$bits(addr_t){sel_cpu}} & cpu_address)
                     | ({$bits(addr_t){sel_vga}} & vga_address);

  assign bus.read = (sel_cpu & cpu_read) | (sel_vga & vga_read);

  assign bus.write = sel_cpu & cpu_write; // VGA only reads

  assign bus.be = ({$bits(be_t){sel_cpu}} & cpu_be)
                | {$bits(be_t){sel_vga}}; // Full word fetches

  assign bus.writedata = {$bits(data_t){sel_cpu}} & cpu_writedata;

endmodule

// ==== rtl/address_decoder.sv ====
`timescale 1ns/10ps

module address_decoder import bus_map_pkg::*; (
  input map_mode_t map,
  bus_request_if.decoder bus,
  input logic cycle_active,
  output chipselect_t chipselect
);

  chipselect_t cs;
  logic boot;

  function automatic logic in_range(
    input logic [31:0] addr,
    input logic [31:0] base,
    input logic [31:0] limit
  );
    in_range = (addr >= base) && (addr <= limit);
  endfunction

  assign boot = (map == map_boot);

  always_comb begin
    cs = '0;
    if (boot && in_range(bus.address, boot_ram_base, boot_ram_limit)) begin
      cs[cs_int_ram] = 1'b1; // RAM at the bottom for booting
    end else if (boot && in_range(bus.address, boot_ssram_base, boot_ssram_limit)) begin
      cs[cs_ssram] = 1'b1;
    end else if (!boot && in_range(bus.address, ssram_base, ssram_limit)) begin
      cs[cs_ssram] = 1'b1;
    end else if (in_range(bus.address, led_base, led_limit)) begin
      cs[cs_led_matrix] = 1'b1;
    end else if (in_range(bus.address, uart0_base, uart0_limit)) begin
      cs[cs_uart0] = 1'b1;
    end else if (in_range(bus.address, uart1_base, uart1_limit)) begin
      cs[cs_uart1] = 1'b1;
    end else if (in_range(bus.address, switches_base, switches_limit)) begin
      cs[cs_switches] = 1'b1;
    end else if (in_range(bus.address, encoder_base, encoder_limit)) begin
      cs[cs_encoder] = 1'b1;
    end else if (in_range(bus.address, sd_card_base, sd_card_limit)) begin
      cs[cs_sd_card] = 1'b1; // SPI
    end else if (in_range(bus.address, lcd_base, lcd_limit)) begin
      cs[cs_lcd] = 1'b1;
    end else if (!boot && in_range(bus.address, int_ram_base, int_ram_limit)) begin
      cs[cs_int_ram] = 1'b1;
    end else if (in_range(bus.address, int_rom_base, int_rom_limit)) begin
      cs[cs_int_rom] = 1'b1;
    end else if (in_range(bus.address, vectors_base, vectors_limit)) begin
      cs[cs_vectors] = 1'b1;
    end
  end

  assign chipselect = cycle_active ? cs : '0; // Quiet between cycles

endmodule

// ==== rtl/bus_fabric.sv ====
`timescale 1ns/10ps

module bus_fabric import bus_map_pkg::*, bus_xfer_pkg::*; #(
  parameter logic [3:0] WAIT_STATES = 4'd0
) (
  input logic clock,
  input logic reset_n,
  input logic [31:0] cpu_address,
  input logic [31:0] vga_address,
  input logic cpu_read,
  input logic vga_read,
  input logic cpu_write,
  input logic [3:0] cpu_be,
  input logic [31:0] cpu_writedata,
  input logic [1:0] map,
  output logic [31:0] address,
  output logic read,
  output logic write,
  output logic cpu_wait,
  output logic vga_wait,
  output logic start,
  output logic burst,
  output logic burst_adv,
  output logic [3:0] be,
  output logic [31:0] writedata,
  output logic [10:0] chipselect
);

  bus_request_if bus ();

  grant_t grant;
  logic cycle_active;
  chipselect_t cs;

  assign burst = 1'b0; // No burst support
  assign burst_adv = 1'b0;

  assign address = bus.address;
  assign read = bus.read;
  assign write = bus.write;
  assign be = bus.be;
  assign writedata = bus.writedata;
  assign chipselect = cs;

  bus_sequencer #(
    .WAIT_STATES(WAIT_STATES)
  ) u_sequencer (
    .clock(clock),
    .reset_n(reset_n),
    .cpu_read(cpu_read),
    .cpu_write(cpu_write),
    .vga_read(vga_read),
    .bus(bus.sequencer),
    .grant(grant),
    .cycle_active(cycle_active),
    .start(start),
    .cpu_wait(cpu_wait),
    .vga_wait(vga_wait)
  );

  master_mux u_mux (
    .cpu_address(cpu_address),
    .cpu_read(cpu_read),
    .cpu_write(cpu_write),
    .cpu_be(cpu_be),
    .cpu_writedata(cpu_writedata),
    .vga_address(vga_address),
    .vga_read(vga_read),
    .grant(grant),
    .bus(bus.mux)
  );

  address_decoder u_decoder (
    .map(map_mode_t'(map)),
    .bus(bus.decoder),
    .cycle_active(cycle_active),
    .chipselect(cs)
  );

endmodule

// ==== testbench/bus_fabric_tb.sv ====
`timescale 1ns/10ps

module bus_fabric_tb;

  localparam int wait_states = 2;
  localparam int reset_cycles = 10;
  localparam int txn_budget = 400;
  localparam int num_txn = 360; // Master cycles actually run, under the budget
  localparam int cycle_limit = txn_budget * (wait_states + 6) + reset_cycles;
  localparam int num_regions = 13;

  logic clock;
  logic reset_n;
  logic [31:0] cpu_address;
  logic [31:0] vga_address;
  logic cpu_read;
  logic vga_read;
  logic cpu_write;
  logic [3:0] cpu_be;
  logic [31:0] cpu_writedata;
  logic [1:0] map;
  logic [31:0] address;
  logic read;
  logic write;
  logic cpu_wait;
  logic vga_wait;
  logic start;
  logic burst;
  logic burst_adv;
  logic [3:0] be;
  logic [31:0] writedata;
  logic [10:0] chipselect;

  logic [31:0] lfsr;
  logic [31:0] region_base [num_regions];
  logic [31:0] region_limit [num_regions];
  int region_cs [num_regions];
  logic [1:0] region_maps [num_regions]; // Bit 1 boot map, bit 0 default map
  int checks;
  int errors;
  int issued;
  int cycle_count;

  bus_fabric #(
    .WAIT_STATES(wait_states)
  ) dut (
    .clock(clock),
    .reset_n(reset_n),
    .cpu_address(cpu_address),
    .vga_address(vga_address),
    .cpu_read(cpu_read),
    .vga_read(vga_read),
    .cpu_write(cpu_write),
    .cpu_be(cpu_be),
    .cpu_writedata(cpu_writedata),
    .map(map),
    .address(address),
    .read(read),
    .write(write),
    .cpu_wait(cpu_wait),
    .vga_wait(vga_wait),
    .start(start),
    .burst(burst),
    .burst_adv(burst_adv),
    .be(be),
    .writedata(writedata),
    .chipselect(chipselect)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic set_region(input int i, input logic [31:0] base, input logic [31:0] limit,
                            input int cs, input logic [1:0] maps);
    region_base[i] = base;
    region_limit[i] = limit;
    region_cs[i] = cs;
    region_maps[i] = maps;
  endtask

  task automatic load_regions();
    set_region(0, 32'h0000_0000, 32'h0000_3fff, 6, 2'b10); // Internal RAM, boot
    set_region(1, 32'h0000_4000, 32'h000f_ffff, 0, 2'b10);
    set_region(2, 32'h0000_0000, 32'h000f_ffff, 0, 2'b01);
    set_region(3, 32'h0080_0000, 32'h0080_07ff, 5, 2'b11);
    set_region(4, 32'h0080_0800, 32'h0080_0807, 4, 2'b11);
    set_region(5, 32'h0080_0808, 32'h0080_080f, 3, 2'b11);
    set_region(6, 32'h0080_0810, 32'h0080_0813, 2, 2'b11);
    set_region(7, 32'h0080_0814, 32'h0080_081f, 1, 2'b11);
    set_region(8, 32'h0080_0820, 32'h0080_0827, 10, 2'b11);
    set_region(9, 32'h0080_0c00, 32'h0080_0cff, 8, 2'b11);
    set_region(10, 32'hffff_8000, 32'hffff_bfff, 6, 2'b01);
    set_region(11, 32'hffff_c000, 32'hffff_ffbf, 7, 2'b11);
    set_region(12, 32'hffff_ffc0, 32'hffff_ffff, 9, 2'b11);
  endtask

  function automatic logic [31:0] next_bits(input int width);
    logic [31:0] value;
    int b;
    value = '0;
    for (b = 0; b < width; b++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  // Regions never overlap within one map, so an OR over the table is one-hot
  function automatic logic [10:0] expected_cs(input logic [31:0] addr, input logic [1:0] mode);
    logic [10:0] cs;
    logic in_map;
    int i;
    cs = '0;
    for (i = 0; i < num_regions; i++) begin
      in_map = (mode == 2'd3) ? region_maps[i][1] : region_maps[i][0];
      if (in_map && addr >= region_base[i] && addr <= region_limit[i]) begin
        cs[region_cs[i]] = 1'b1;
      end
    end
    return cs;
  endfunction

  function automatic logic [31:0] pick_address();
    logic [31:0] a;
    logic [1:0] offset;
    int i;
    if (next_bits(1) == 0) begin
      return next_bits(32);
    end
    i = next_bits(4) % num_regions;
    a = next_bits(1) ? region_limit[i] : region_base[i];
    offset = next_bits(2);
    if (offset == 2'd0) begin
      a = a - 1; // Just below an edge
    end else if (offset == 2'd1) begin
      a = a + 1;
    end
    return a;
  endfunction

  function automatic int pick_drop();
    if (next_bits(3) != 0) begin
      return 0;
    end
    return 1 + next_bits(2) % (wait_states + 2); // Somewhere in start or pre
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_idle();
    check_value("start", start, 1'b0);
    check_value("cpu_wait", cpu_wait, 1'b1);
    check_value("vga_wait", vga_wait, 1'b1);
    check_value("chipselect", chipselect, '0);
    check_value("address", address, '0);
    check_value("read", read, 1'b0);
    check_value("write", write, 1'b0);
    check_value("be", be, '0);
    check_value("writedata", writedata, '0);
    check_value("burst", burst, 1'b0);
    check_value("burst_adv", burst_adv, 1'b0);
  endtask

  task automatic check_active(input int m, input int n);
    logic cpu_side;
    logic [31:0] addr;
    cpu_side = (m == 0);
    addr = cpu_side ? cpu_address : vga_address;
    check_value("start", start, n == 1);
    check_value("cpu_wait", cpu_wait, !(cpu_side && n >= wait_states + 3));
    check_value("vga_wait", vga_wait, !(!cpu_side && n >= wait_states + 3));
    check_value("chipselect", chipselect, expected_cs(addr, map));
    check_value("address", address, addr);
    check_value("read", read, cpu_side ? cpu_read : vga_read);
    check_value("write", write, cpu_side ? cpu_write : 1'b0);
    check_value("be", be, cpu_side ? cpu_be : 4'hf);
    check_value("writedata", writedata, cpu_side ? cpu_writedata : 32'h0);
    check_value("burst", burst, 1'b0);
    check_value("burst_adv", burst_adv, 1'b0);
  endtask

  task automatic release_request(input int m);
    if (m == 0) begin
      cpu_read = 1'b0;
      cpu_write = 1'b0;
    end else begin
      vga_read = 1'b0;
    end
  endtask

  // Edge n = 1 is the edge that samples the request
  task automatic run_master(input int m, input int drop_n);
    logic seen_low;
    int n;
    n = 0;
    seen_low = 1'b0;
    while ((m == 0) ? (cpu_read || cpu_write) : vga_read) begin
      @(posedge clock);
      #1;
      n++;
      if (seen_low || n == drop_n) begin
        release_request(m);
      end
      #1;
      check_active(m, n);
      seen_low = (m == 0) ? !cpu_wait : !vga_wait;
    end
    @(posedge clock);
    #2;
    check_idle(); // Back in idle
    issued++;
  endtask

  task automatic run_slot();
    logic [1:0] kind;
    int cpu_drop;
    int vga_drop;
    kind = next_bits(2); // 1 VGA alone, 2 both, else CPU alone
    cpu_drop = pick_drop();
    vga_drop = pick_drop();
    @(posedge clock);
    #1;
    map = next_bits(2);
    if (kind != 2'd1) begin
      cpu_address = pick_address();
      cpu_write = next_bits(1);
      cpu_read = !cpu_write;
      cpu_be = next_bits(4);
      cpu_writedata = next_bits(32);
    end
    if (kind == 2'd1 || kind == 2'd2) begin
      vga_address = pick_address();
      vga_read = 1'b1;
    end
    #1;
    check_idle();
    if (cpu_read || cpu_write) begin
      run_master(0, cpu_drop); // CPU wins a tie
    end
    if (vga_read) begin
      run_master(1, vga_drop);
    end
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the transfers did not complete", cycle_count);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    checks = 0;
    errors = 0;
    issued = 0;
    lfsr = 32'hcea9_56fa;
    reset_n = 1'b0;
    cpu_address = '0;
    vga_address = '0;
    cpu_read = 1'b0;
    vga_read = 1'b0;
    cpu_write = 1'b0;
    cpu_be = '0;
    cpu_writedata = '0;
    map = '0;
    load_regions();
    repeat (reset_cycles) @(posedge clock);
    #1;
    check_idle();
    reset_n = 1'b1;
    @(posedge clock);
    #2;
    check_idle();
    while (issued < num_txn) begin
      run_slot();
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
rtl/bus_map_pkg.sv
rtl/bus_xfer_pkg.sv
rtl/bus_request_if.sv
rtl/bus_sequencer.sv
rtl/master_mux.sv
rtl/address_decoder.sv
rtl/bus_fabric.sv
testbench/bus_fabric_tb.sv

// ==== Bender.yml ====
package:
  name: bus_fabric

sources:
  - target: rtl
    files:
      - rtl/bus_map_pkg.sv
      - rtl/bus_xfer_pkg.sv
      - rtl/bus_request_if.sv
      - rtl/bus_sequencer.sv
      - rtl/master_mux.sv
      - rtl/address_decoder.sv
      - rtl/bus_fabric.sv

  - target: test
    files:
      - testbench/bus_fabric_tb.sv
